// ==== sources.f ====
+incdir+common
common/rtc_pkg.sv
design/rtc_core.sv
design/rtc_regs.sv
design/rtc_alarm.sv
design/rtc_top.sv
dv/rtc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RTC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module rtc_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vrtc_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== dv/rtc_tb.sv ====
// RTC testbench; 100 ns clock, every cycle checked against a reference model, stops at 3000 cycles
`include "rtc_defines.svh"

module rtc_tb
    import rtc_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [`RTC_NSEC_W:0] NS_LIM = (`RTC_NSEC_W+1)'(`RTC_NSEC_PER_SEC);
    // About ten times the few hundred cycles the tests take
    localparam int MAX_CYCLES = 3000;

    logic        clk;
    logic        rst;
    logic        wr_en;
    logic        rd_en;
    logic [3:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rdata_valid;
    rtc_sec_t    rtc_sec;
    rtc_nsec_t   rtc_nsec;
    logic        pps_out;
    logic        alarm_irq;

    integer    seed = 32'hcb58963a;
    int        err_cnt = 0;
    int        err_mark = 0;
    int        test_cnt = 0;
    int        fail_cnt = 0;
    int        cycles = 0;
    rtc_inc_t  cur_inc;
    rtc_sec_t  s;
    rtc_nsec_t n;

    // Reference model state
    rtc_sec_t    m_sec;
    rtc_nsec_t   m_nsec;
    logic        m_pps;
    logic        m_irq;
    rtc_inc_t    m_inc;
    rtc_sec_t    m_set_sec;
    rtc_nsec_t   m_set_nsec;
    logic        m_adj_sub;
    rtc_nsec_t   m_adj_nsec;
    rtc_sec_t    m_snap_sec;
    rtc_nsec_t   m_snap_nsec;
    rtc_sec_t    m_alarm_sec;
    logic        m_alarm_en;
    logic        p_set;
    logic        p_adj;
    logic        p_cap;
    logic        p_clr;
    logic        m_rd_valid;
    logic [31:0] m_rdata;
    logic        ctrl_wr;

    rtc_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .rtc_sec     (rtc_sec),
        .rtc_nsec    (rtc_nsec),
        .pps_out     (pps_out),
        .alarm_irq   (alarm_irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    assign ctrl_wr = wr_en && (addr == REG_CTRL);

    function automatic logic [31:0] expected_read(input logic [3:0] a);
        logic [31:0] v;
        v = '0;
        case (rtc_reg_e'(a))
            REG_SET_SEC:   v = m_set_sec;
            REG_SET_NSEC:  v = 32'(m_set_nsec);
            REG_ADJ:       v = {m_adj_sub, 1'b0, m_adj_nsec};
            REG_INC:       v = 32'(m_inc);
            REG_SNAP_SEC:  v = m_snap_sec;
            REG_SNAP_NSEC: v = 32'(m_snap_nsec);
            REG_ALARM_SEC: v = m_alarm_sec;
            REG_ALARM_CFG: v = 32'(m_alarm_en);
            REG_STATUS:    v = 32'(m_irq);
            default:       v = '0;
        endcase
        return v;
    endfunction

    always @(posedge clk) begin : ref_model
        logic [`RTC_NSEC_W:0] step;
        logic [`RTC_NSEC_W:0] sum;
        logic [`RTC_NSEC_W:0] wrap;
        step = (`RTC_NSEC_W+1)'(m_inc);
        if (p_adj && !m_adj_sub) begin
            step = step + {1'b0, m_adj_nsec};
        end
        // Subtracting more than one increment holds the time still
        if (p_adj && m_adj_sub) begin
            if ({1'b0, m_adj_nsec} > step) begin
                step = '0;
            end else begin
                step = step - {1'b0, m_adj_nsec};
            end
        end
        sum  = {1'b0, m_nsec} + step;
        wrap = sum - NS_LIM;
        if (rst) begin
            m_sec       <= '0;
            m_nsec      <= '0;
            m_pps       <= 1'b0;
            m_irq       <= 1'b0;
            m_inc       <= rtc_inc_t'(`RTC_INC_RESET);
            m_alarm_sec <= '0;
            m_alarm_en  <= 1'b0;
            p_set       <= 1'b0;
            p_adj       <= 1'b0;
            p_cap       <= 1'b0;
            p_clr       <= 1'b0;
            m_rd_valid  <= 1'b0;
        end else begin
            p_set <= ctrl_wr && wdata[0];
            p_adj <= ctrl_wr && wdata[1];
            p_cap <= ctrl_wr && wdata[2];
            p_clr <= ctrl_wr && wdata[3];
            if (wr_en) begin
                case (rtc_reg_e'(addr))
                    REG_SET_SEC:   m_set_sec   <= wdata;
                    REG_SET_NSEC:  m_set_nsec  <= wdata[`RTC_NSEC_W-1:0];
                    REG_ADJ: begin
                        m_adj_sub  <= wdata[31];
                        m_adj_nsec <= wdata[`RTC_NSEC_W-1:0];
                    end
                    REG_INC:       m_inc       <= wdata[`RTC_INC_W-1:0];
                    REG_ALARM_SEC: m_alarm_sec <= wdata;
                    REG_ALARM_CFG: m_alarm_en  <= wdata[0];
                    default: ;
                endcase
            end
            if (p_set) begin
                m_sec  <= m_set_sec;
                m_nsec <= m_set_nsec;
                m_pps  <= 1'b0;
            end else if (sum >= NS_LIM) begin
                m_sec  <= m_sec + 32'd1;
                m_nsec <= wrap[`RTC_NSEC_W-1:0];
                m_pps  <= 1'b1;
            end else begin
                m_nsec <= sum[`RTC_NSEC_W-1:0];
                m_pps  <= 1'b0;
            end
            if (p_cap) begin
                m_snap_sec  <= m_sec;
                m_snap_nsec <= m_nsec;
            end
            if (p_clr) begin
                m_irq <= 1'b0;
            end else if (m_pps && m_alarm_en && (m_sec == m_alarm_sec)) begin
                m_irq <= 1'b1;
            end
            m_rd_valid <= rd_en;
            if (rd_en) begin
                m_rdata <= expected_read(addr);
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks against the model
    // ------------------------------------------------------------------

    a_sec: assert property (@(posedge clk) disable iff (rst) rtc_sec == m_sec)
        else begin
            err_cnt++;
            $display("FAILED t=%0t rtc_sec got %0d expected %0d", $time,
                     $sampled(rtc_sec), $sampled(m_sec));
        end

    a_nsec: assert property (@(posedge clk) disable iff (rst) rtc_nsec == m_nsec)
        else begin
            err_cnt++;
            $display("FAILED t=%0t rtc_nsec got %0d expected %0d", $time,
                     $sampled(rtc_nsec), $sampled(m_nsec));
        end

    a_pps: assert property (@(posedge clk) disable iff (rst) pps_out == m_pps)
        else begin
            err_cnt++;
            $display("FAILED t=%0t pps_out got %0b expected %0b", $time,
                     $sampled(pps_out), $sampled(m_pps));
        end

    a_irq: assert property (@(posedge clk) disable iff (rst) alarm_irq == m_irq)
        else begin
            err_cnt++;
            $display("FAILED t=%0t alarm_irq got %0b expected %0b", $time,
                     $sampled(alarm_irq), $sampled(m_irq));
        end

    a_valid: assert property (@(posedge clk) disable iff (rst) rdata_valid == m_rd_valid)
        else begin
            err_cnt++;
            $display("FAILED t=%0t rdata_valid got %0b expected %0b", $time,
                     $sampled(rdata_valid), $sampled(m_rd_valid));
        end

    a_rdata: assert property (@(posedge clk) disable iff (rst) rdata_valid |-> rdata == m_rdata)
        else begin
            err_cnt++;
            $display("FAILED t=%0t rdata got %08h expected %08h", $time,
                     $sampled(rdata), $sampled(m_rdata));
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a wait for the DUT never finished", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus helpers called at a falling edge
    // ------------------------------------------------------------------

    function automatic logic [31:0] rand_below(input logic [31:0] limit);
        logic [31:0] r;
        r = $random(seed);
        return r % limit;
    endfunction

    task automatic idle(input int n_cyc);
        repeat (n_cyc) @(negedge clk);
    endtask

    task automatic reg_write(input logic [3:0] a, input logic [31:0] d);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic reg_read(input logic [3:0] a);
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        rd_en = 1'b0;
        // Data is checked at the next edge
        @(negedge clk);
    endtask

    task automatic set_time(input rtc_sec_t sec, input rtc_nsec_t nsec);
        reg_write(REG_SET_SEC, sec);
        reg_write(REG_SET_NSEC, 32'(nsec));
        reg_write(REG_CTRL, 32'h1);
        idle(2);
    endtask

    task automatic wait_pps();
        while (pps_out !== 1'b1) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic wait_irq();
        while (alarm_irq !== 1'b1) @(negedge clk);
    endtask

    task automatic test_done(input string name);
        test_cnt++;
        if (err_cnt != err_mark) begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
        end else begin
            $display("test %0d %s: ok", test_cnt, name);
        end
        err_mark = err_cnt;
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------

    initial begin
        rst   = 1'b1;
        wr_en = 1'b0;
        rd_en = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        idle(4);
        test_done("reset state");

        cur_inc = rtc_inc_t'(rand_below(32'd255) + 32'd1);
        reg_write(REG_INC, 32'(cur_inc));
        s = $random(seed);
        n = rtc_nsec_t'(`RTC_NSEC_PER_SEC - 20 * int'(cur_inc));
        set_time(s, n);
        wait_pps();
        idle(10);
        test_done("free run and rollover");

        // Five increments later the next set acts on the edge that would roll over
        s = $random(seed);
        n = rtc_nsec_t'(`RTC_NSEC_PER_SEC - 5 * int'(cur_inc));
        set_time(s, n);
        repeat (3) begin
            s = $random(seed);
            n = rtc_nsec_t'(rand_below(`RTC_NSEC_PER_SEC));
            set_time(s, n);
            idle(3);
        end
        test_done("set");

        reg_write(REG_ADJ, rand_below(32'd1_000_000));
        reg_write(REG_CTRL, 32'h2);
        idle(3);
        reg_write(REG_ADJ, 32'h8000_0000 | rand_below(32'(cur_inc)));
        reg_write(REG_CTRL, 32'h2);
        idle(3);
        // Larger than one increment
        reg_write(REG_ADJ, 32'h8000_0000 | (32'(cur_inc) + 32'd100));
        reg_write(REG_CTRL, 32'h2);
        idle(3);
        test_done("adjust");

        reg_write(REG_CTRL, 32'h4);
        idle(3);
        reg_read(REG_SNAP_SEC);
        reg_read(REG_SNAP_NSEC);
        cur_inc = rtc_inc_t'(rand_below(32'd255) + 32'd1);
        reg_write(REG_INC, 32'(cur_inc));
        reg_read(REG_INC);
        reg_write(REG_ALARM_SEC, $random(seed));
        reg_read(REG_ALARM_SEC);
        reg_write(REG_ALARM_CFG, 32'h1);
        reg_read(REG_ALARM_CFG);
        reg_write(REG_ALARM_CFG, 32'h0);
        reg_read(REG_CTRL);
        reg_read(4'd10);
        reg_read(4'd15);
        test_done("capture and readback");

        s = $random(seed);
        n = rtc_nsec_t'(`RTC_NSEC_PER_SEC - 30 * int'(cur_inc));
        reg_write(REG_ALARM_SEC, s + 32'd1);
        reg_write(REG_ALARM_CFG, 32'h1);
        set_time(s, n);
        wait_irq();
        reg_read(REG_STATUS);
        reg_write(REG_CTRL, 32'h8);
        idle(3);
        reg_read(REG_STATUS);
        // Same second again with the alarm off
        reg_write(REG_ALARM_CFG, 32'h0);
        set_time(s, n);
        wait_pps();
        idle(3);
        reg_read(REG_STATUS);
        test_done("alarm");

        $display("tests %0d, failed %0d, check errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== design/rtc_top.sv ====
// RTC subsystem top; addresses 10 to 15 are unmapped and read zero
`include "rtc_defines.svh"

module rtc_top
    import rtc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // Register bus
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  logic [`RTC_ADDR_W-1:0] addr,
    input  logic [31:0]            wdata,
    output logic [31:0]            rdata,
    output logic                   rdata_valid,
    // Time and events
    output rtc_sec_t               rtc_sec,
    output rtc_nsec_t              rtc_nsec,
    output logic                   pps_out,
    output logic                   alarm_irq
);

    // Register block to core
    logic      set_cmd;
    rtc_sec_t  set_sec;
    rtc_nsec_t set_nsec;
    logic      adj_cmd;
    logic      adj_sub;
    rtc_nsec_t adj_nsec;
    logic      cap_cmd;
    rtc_inc_t  inc_nsec;

    // Core to register block
    rtc_sec_t  snap_sec;
    rtc_nsec_t snap_nsec;

    // Register block to alarm
    rtc_sec_t  alarm_sec;
    logic      alarm_en;
    logic      alarm_clr;

    rtc_regs i_regs (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .addr        (rtc_reg_e'(addr)),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .snap_sec    (snap_sec),
        .snap_nsec   (snap_nsec),
        .alarm_irq   (alarm_irq),
        .set_cmd     (set_cmd),
        .set_sec     (set_sec),
        .set_nsec    (set_nsec),
        .adj_cmd     (adj_cmd),
        .adj_sub     (adj_sub),
        .adj_nsec    (adj_nsec),
        .cap_cmd     (cap_cmd),
        .inc_nsec    (inc_nsec),
        .alarm_sec   (alarm_sec),
        .alarm_en    (alarm_en),
        .alarm_clr   (alarm_clr)
    );

    rtc_core i_core (
        .clk       (clk),
        .rst       (rst),
        .set_cmd   (set_cmd),
        .set_sec   (set_sec),
        .set_nsec  (set_nsec),
        .adj_cmd   (adj_cmd),
        .adj_sub   (adj_sub),
        .adj_nsec  (adj_nsec),
        .cap_cmd   (cap_cmd),
        .inc_nsec  (inc_nsec),
        .rtc_sec   (rtc_sec),
        .rtc_nsec  (rtc_nsec),
        .snap_sec  (snap_sec),
        .snap_nsec (snap_nsec),
        .pps_out   (pps_out)
    );

    rtc_alarm i_alarm (
        .clk       (clk),
        .rst       (rst),
        .rtc_sec   (rtc_sec),
        .pps_out   (pps_out),
        .alarm_sec (alarm_sec),
        .alarm_en  (alarm_en),
        .alarm_clr (alarm_clr),
        .alarm_irq (alarm_irq)
    );

endmodule

// ==== design/rtc_alarm.sv ====
// Seconds alarm; matches only on a PPS, so a set straight onto alarm_sec does not fire it
`include "rtc_defines.svh"

module rtc_alarm
    import rtc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // Time from the core
    input  rtc_sec_t rtc_sec,
    input  logic     pps_out,
    // Configuration
    input  rtc_sec_t alarm_sec,
    input  logic     alarm_en,
    input  logic     alarm_clr,
    // Level interrupt
    output logic     alarm_irq
);

    logic alarm_hit;

    // ------------------------------------------------------------------
    // Compare
    // ------------------------------------------------------------------

    // During the PPS cycle rtc_sec already holds the new second
    assign alarm_hit = pps_out && alarm_en && (rtc_sec == alarm_sec);

    // ------------------------------------------------------------------
    // Latched interrupt
    // ------------------------------------------------------------------

    // Clear has priority over a hit on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            alarm_irq <= 1'b0;
        end else if (alarm_clr) begin
            alarm_irq <= 1'b0;
        end else if (alarm_hit) begin
            alarm_irq <= 1'b1;
        end
    end

    a_irq_after_pps: assert property (
        @(posedge clk) disable iff (rst)
        $rose(alarm_irq) |-> $past(pps_out)
    ) else $error("rtc_alarm: alarm_irq rose without a preceding PPS");

endmodule

// ==== design/rtc_regs.sv ====
// Register port; one access per cycle, read data valid one cycle after rd_en, no wait states
`include "rtc_defines.svh"

module rtc_regs
    import rtc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Register bus
    input  logic        wr_en,
    input  logic        rd_en,
    input  rtc_reg_e    addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rdata_valid,
    // Status from core and alarm
    input  rtc_sec_t    snap_sec,
    input  rtc_nsec_t   snap_nsec,
    input  logic        alarm_irq,
    // Core controls
    output logic        set_cmd,
    output rtc_sec_t    set_sec,
    output rtc_nsec_t   set_nsec,
    output logic        adj_cmd,
    output logic        adj_sub,
    output rtc_nsec_t   adj_nsec,
    output logic        cap_cmd,
    output rtc_inc_t    inc_nsec,
    // Alarm controls
    output rtc_sec_t    alarm_sec,
    output logic        alarm_en,
    output logic        alarm_clr
);

    // REG_CTRL command bits
    localparam int CTRL_SET = 0;
    localparam int CTRL_ADJ = 1;
    localparam int CTRL_CAP = 2;
    localparam int CTRL_CLR = 3;

    logic        ctrl_wr;
    logic [31:0] rd_mux;

    assign ctrl_wr = wr_en && (addr == REG_CTRL);

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------

    // Staging values, only meaningful once a command uses them
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (addr)
                REG_SET_SEC:  set_sec  <= wdata[`RTC_SEC_W-1:0];
                REG_SET_NSEC: set_nsec <= wdata[`RTC_NSEC_W-1:0];
                REG_ADJ: begin
                    adj_sub  <= wdata[31];
                    adj_nsec <= wdata[`RTC_NSEC_W-1:0];
                end
                default: ;
            endcase
        end
    end

    // Configuration
    always_ff @(posedge clk) begin
        if (rst) begin
            inc_nsec  <= rtc_inc_t'(`RTC_INC_RESET);
            alarm_sec <= '0;
            alarm_en  <= 1'b0;
        end else if (wr_en) begin
            case (addr)
                REG_INC:       inc_nsec  <= wdata[`RTC_INC_W-1:0];
                REG_ALARM_SEC: alarm_sec <= wdata[`RTC_SEC_W-1:0];
                REG_ALARM_CFG: alarm_en  <= wdata[0];
                default: ;
            endcase
        end
    end

    // Command strobes, one cycle wide and acting on the next edge
    always_ff @(posedge clk) begin
        if (rst) begin
            set_cmd   <= 1'b0;
            adj_cmd   <= 1'b0;
            cap_cmd   <= 1'b0;
            alarm_clr <= 1'b0;
        end else begin
            set_cmd   <= ctrl_wr && wdata[CTRL_SET];
            adj_cmd   <= ctrl_wr && wdata[CTRL_ADJ];
            cap_cmd   <= ctrl_wr && wdata[CTRL_CAP];
            alarm_clr <= ctrl_wr && wdata[CTRL_CLR];
        end
    end

    // ------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------

    always_comb begin
        rd_mux = '0;
        case (addr)
            REG_SET_SEC:   rd_mux[`RTC_SEC_W-1:0]  = set_sec;
            REG_SET_NSEC:  rd_mux[`RTC_NSEC_W-1:0] = set_nsec;
            REG_ADJ: begin
                rd_mux[31]               = adj_sub;
                rd_mux[`RTC_NSEC_W-1:0] = adj_nsec;
            end
            REG_INC:       rd_mux[`RTC_INC_W-1:0]  = inc_nsec;
            REG_SNAP_SEC:  rd_mux[`RTC_SEC_W-1:0]  = snap_sec;
            REG_SNAP_NSEC: rd_mux[`RTC_NSEC_W-1:0] = snap_nsec;
            REG_ALARM_SEC: rd_mux[`RTC_SEC_W-1:0]  = alarm_sec;
            REG_ALARM_CFG: rd_mux[0]               = alarm_en;
            REG_STATUS:    rd_mux[0]               = alarm_irq;
            // REG_CTRL is write-only, unmapped space reads zero
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd_en;
        end
    end

    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(wr_en && rd_en)
    ) else $error("rtc_regs: wr_en and rd_en high together");

endmodule

// ==== design/rtc_core.sv ====
// Time counters; set_nsec and add adjust must be below one billion, only one rollover per clock
`include "rtc_defines.svh"

module rtc_core
    import rtc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Set
    input  logic      set_cmd,
    input  rtc_sec_t  set_sec,
    input  rtc_nsec_t set_nsec,
    // One-shot phase adjust
    input  logic      adj_cmd,
    input  logic      adj_sub,
    input  rtc_nsec_t adj_nsec,
    // Snapshot
    input  logic      cap_cmd,
    // Nanoseconds per clock
    input  rtc_inc_t  inc_nsec,
    // Time out
    output rtc_sec_t  rtc_sec,
    output rtc_nsec_t rtc_nsec,
    output rtc_sec_t  snap_sec,
    output rtc_nsec_t snap_nsec,
    output logic      pps_out
);

    // One extra bit so a sum up to two seconds fits
    localparam logic [`RTC_NSEC_W:0] NSEC_LIMIT = (`RTC_NSEC_W+1)'(`RTC_NSEC_PER_SEC);
    localparam logic [`RTC_NSEC_W:0] ADJ_MAX =
        NSEC_LIMIT - (`RTC_NSEC_W+1)'((1 << `RTC_INC_W) - 1);

    rtc_sec_t  sec_cnt;
    rtc_nsec_t nsec_cnt;

    logic [`RTC_NSEC_W:0] inc_ext;
    logic [`RTC_NSEC_W:0] adj_ext;
    logic [`RTC_NSEC_W:0] step;
    logic [`RTC_NSEC_W:0] nsec_sum;
    logic [`RTC_NSEC_W:0] nsec_wrap;
    logic                 rollover;

    // ------------------------------------------------------------------
    // Step for this edge
    // ------------------------------------------------------------------

    assign inc_ext = {{(`RTC_NSEC_W+1-`RTC_INC_W){1'b0}}, inc_nsec};
    assign adj_ext = {1'b0, adj_nsec};

    always_comb begin
        step = inc_ext;
        if (adj_cmd) begin
            if (!adj_sub) begin
                step = inc_ext + adj_ext;
            end else if (adj_ext > inc_ext) begin
                // Time never runs backwards, the step stops at zero
                step = '0;
            end else begin
                step = inc_ext - adj_ext;
            end
        end
    end

    assign nsec_sum  = {1'b0, nsec_cnt} + step;
    assign nsec_wrap = nsec_sum - NSEC_LIMIT;
    assign rollover  = (nsec_sum >= NSEC_LIMIT);

    // ------------------------------------------------------------------
    // Counters
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            nsec_cnt <= '0;
            sec_cnt  <= '0;
        end else if (set_cmd) begin
            nsec_cnt <= set_nsec;
            sec_cnt  <= set_sec;
        end else begin
            if (rollover) begin
                nsec_cnt <= nsec_wrap[`RTC_NSEC_W-1:0];
                sec_cnt  <= sec_cnt + 1'b1;
            end else begin
                nsec_cnt <= nsec_sum[`RTC_NSEC_W-1:0];
            end
        end
    end

    // PPS marks the first cycle of the new second, a set never pulses it
    always_ff @(posedge clk) begin
        if (rst) begin
            pps_out <= 1'b0;
        end else begin
            pps_out <= rollover && !set_cmd;
        end
    end

    // Snapshot holds the time seen just before the capture edge
    always_ff @(posedge clk) begin
        if (cap_cmd) begin
            snap_sec  <= sec_cnt;
            snap_nsec <= nsec_cnt;
        end
    end

    assign rtc_sec  = sec_cnt;
    assign rtc_nsec = nsec_cnt;

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    a_nsec_range: assert property (
        @(posedge clk) disable iff (rst)
        rtc_nsec < NSEC_LIMIT
    ) else $error("rtc_core: nanoseconds %0d out of range", rtc_nsec);

    // Keeps inc plus adjust below one second, so one subtraction is enough
    a_adj_range: assert property (
        @(posedge clk) disable iff (rst)
        (adj_cmd && !adj_sub) |-> (adj_ext < ADJ_MAX)
    ) else $error("rtc_core: add adjust %0d too large", adj_nsec);

    a_pps_single: assert property (
        @(posedge clk) disable iff (rst)
        pps_out |=> !pps_out
    ) else $error("rtc_core: pps_out high two cycles running");

endmodule

// ==== common/rtc_pkg.sv ====
// Shared RTC types; the address map is a fixed 4-bit space with ten registers, the rest read zero
`include "rtc_defines.svh"

package rtc_pkg;

    // Time fields
    typedef logic [`RTC_SEC_W-1:0]  rtc_sec_t;
    typedef logic [`RTC_NSEC_W-1:0] rtc_nsec_t;

    // Nanoseconds added on every clock
    typedef logic [`RTC_INC_W-1:0]  rtc_inc_t;

    // Register map
    typedef enum logic [`RTC_ADDR_W-1:0] {
        REG_CTRL      = 0,
        REG_SET_SEC   = 1,
        REG_SET_NSEC  = 2,
        REG_ADJ       = 3,
        REG_INC       = 4,
        REG_SNAP_SEC  = 5,
        REG_SNAP_NSEC = 6,
        REG_ALARM_SEC = 7,
        REG_ALARM_CFG = 8,
        REG_STATUS    = 9
    } rtc_reg_e;

endpackage

// ==== common/rtc_defines.svh ====
// Widths and limits for the RTC; per-clock step plus any add adjust must stay below one second
`ifndef RTC_DEFINES_SVH
`define RTC_DEFINES_SVH

// Nanoseconds roll over at this value
`define RTC_NSEC_PER_SEC 1_000_000_000

// Counter widths
`define RTC_SEC_W 32
`define RTC_NSEC_W 30

// Per-clock increment, reset value suits a 100 MHz clock
`define RTC_INC_W 8
`define RTC_INC_RESET 10

// Register port
`define RTC_ADDR_W 4

`endif
